// File: arp_cache.f
+incdir+include
logic/arp_cache_pkg.sv
logic/arp_table_ram.sv
logic/arp_way_scan.sv
logic/arp_request_unit.sv
logic/arp_cache_ctrl.sv
logic/arp_cache.sv
verification/arp_cache_assert.sv
verification/arp_cache_tb.sv

// File: include/arp_cache_cfg.svh
`ifndef ARP_CACHE_CFG_SVH
`define ARP_CACHE_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Table geometry

// Hash buckets, one line of ways each
`define ARP_LINES_PER_WAY 16

// Ways per line, walked one after another
`define ARP_NUM_WAYS 4

//////////////////////////////////////////////////////////////////////
// Field widths

`define ARP_IP_BITS 32
`define ARP_MAC_BITS 48

// Table address is {line, way}
`define ARP_LINE_BITS ($clog2(`ARP_LINES_PER_WAY))
`define ARP_WAY_BITS ($clog2(`ARP_NUM_WAYS))
`define ARP_ADDR_BITS (`ARP_LINE_BITS + `ARP_WAY_BITS)

`endif

// File: logic/arp_cache.sv
`timescale 1ns/1ps
`include "arp_cache_cfg.svh"

module arp_cache import arp_cache_pkg::*; (
	input logic clk,
	input logic reset,
	input logic lookup_en,
	input logic [`ARP_IP_BITS-1:0] lookup_ip,
	input logic learn_en,
	input logic [`ARP_IP_BITS-1:0] learn_ip,
	input logic [`ARP_MAC_BITS-1:0] learn_mac,
	output logic lookup_done,
	output logic lookup_hit,
	output logic [`ARP_MAC_BITS-1:0] lookup_mac
);

	//////////////////////////////////////////////////////////////////////
	// Request unit to controller

	logic lookup_take;
	logic learn_take;
	logic learn_clear;
	logic lookup_pending;
	logic learn_pending;
	arp_lookup_t pending_lookup;
	arp_learn_t pending_learn;

	//////////////////////////////////////////////////////////////////////
	// Table access and scan

	logic rd_en;
	logic [`ARP_ADDR_BITS-1:0] rd_addr;
	logic wr_en;
	logic [`ARP_ADDR_BITS-1:0] wr_addr;
	arp_entry_t wr_data;
	arp_rd_result_t rd_result;

	logic scan_start;
	logic scan_active;
	logic [`ARP_IP_BITS-1:0] target_ip;
	logic match;
	logic [`ARP_ADDR_BITS-1:0] match_addr;
	logic [`ARP_MAC_BITS-1:0] match_mac;
	logic [`ARP_ADDR_BITS-1:0] victim_addr;

	// Hash and hold incoming strobes
	arp_request_unit request_unit (
		.clk(clk),
		.reset(reset),
		.lookup_en(lookup_en),
		.lookup_ip(lookup_ip),
		.learn_en(learn_en),
		.learn_ip(learn_ip),
		.learn_mac(learn_mac),
		.lookup_take(lookup_take),
		.learn_take(learn_take),
		.learn_clear(learn_clear),
		.lookup_pending(lookup_pending),
		.learn_pending(learn_pending),
		.pending_lookup(pending_lookup),
		.pending_learn(pending_learn)
	);

	// Sequencer for the way walk
	arp_cache_ctrl ctrl (
		.clk(clk),
		.reset(reset),
		.lookup_pending(lookup_pending),
		.pending_lookup(pending_lookup),
		.learn_pending(learn_pending),
		.pending_learn(pending_learn),
		.match(match),
		.match_addr(match_addr),
		.match_mac(match_mac),
		.victim_addr(victim_addr),
		.lookup_take(lookup_take),
		.learn_take(learn_take),
		.learn_clear(learn_clear),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.scan_start(scan_start),
		.scan_active(scan_active),
		.target_ip(target_ip),
		.lookup_done(lookup_done),
		.lookup_hit(lookup_hit),
		.lookup_mac(lookup_mac)
	);

	// Read fields land straight in the result struct
	arp_table_ram #(
		.ENTRY_T(arp_entry_t),
		.ADDR_BITS(`ARP_ADDR_BITS)
	) table_ram (
		.clk(clk),
		.reset(reset),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_valid(rd_result.valid),
		.rd_data(rd_result.entry),
		.rd_data_addr(rd_result.addr)
	);

	arp_way_scan way_scan (
		.clk(clk),
		.reset(reset),
		.rd_result(rd_result),
		.scan_start(scan_start),
		.scan_active(scan_active),
		.target_ip(target_ip),
		.match(match),
		.match_addr(match_addr),
		.match_mac(match_mac),
		.victim_addr(victim_addr)
	);

endmodule

// File: logic/arp_cache_ctrl.sv
`timescale 1ns/1ps
`include "arp_cache_cfg.svh"

module arp_cache_ctrl import arp_cache_pkg::*; (
	input logic clk,
	input logic reset,
	input logic lookup_pending,
	input arp_lookup_t pending_lookup,
	input logic learn_pending,
	input arp_learn_t pending_learn,
	input logic match,
	input logic [`ARP_ADDR_BITS-1:0] match_addr,
	input logic [`ARP_MAC_BITS-1:0] match_mac,
	input logic [`ARP_ADDR_BITS-1:0] victim_addr,
	output logic lookup_take,
	output logic learn_take,
	output logic learn_clear,
	output logic rd_en,
	output logic [`ARP_ADDR_BITS-1:0] rd_addr,
	output logic wr_en,
	output logic [`ARP_ADDR_BITS-1:0] wr_addr,
	output arp_entry_t wr_data,
	output logic scan_start,
	output logic scan_active,
	output logic [`ARP_IP_BITS-1:0] target_ip,
	output logic lookup_done,
	output logic lookup_hit,
	output logic [`ARP_MAC_BITS-1:0] lookup_mac
);

	localparam int WAY_BITS = `ARP_WAY_BITS;

	arp_state_t state;
	logic [WAY_BITS-1:0] next_way;
	logic addr_at_end;
	logic in_lookup_scan;
	logic in_learn_scan;

	// Way bits of the read address step through the line
	assign next_way = rd_addr[WAY_BITS-1:0] + 1'b1;
	assign addr_at_end = rd_addr[WAY_BITS-1:0] == '1;

	//////////////////////////////////////////////////////////////////////
	// Decoded strobes

	always_comb begin
		// Lookups win over learns
		lookup_take = (state == IDLE) && lookup_pending;
		learn_take = (state == IDLE) && !lookup_pending && learn_pending;
		scan_start = lookup_take || learn_take;
		// Read results are valid from stage 2 on
		in_lookup_scan = state inside {LOOKUP_2, LOOKUP_3, LOOKUP_4};
		in_learn_scan = state inside {LEARN_2, LEARN_3, LEARN_4};
		scan_active = in_lookup_scan || in_learn_scan;
		// Learn is finished once it writes, either in place or to the victim
		learn_clear = (in_learn_scan && match) || (state == LEARN_5);
	end

	//////////////////////////////////////////////////////////////////////
	// Walk sequencer

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			rd_en <= 1'b0;
			wr_en <= 1'b0;
			lookup_done <= 1'b0;
			lookup_hit <= 1'b0;
		end else begin
			// Single cycle strobes by default
			rd_en <= 1'b0;
			wr_en <= 1'b0;
			lookup_done <= 1'b0;
			lookup_hit <= 1'b0;

			case (state)
				IDLE: begin
					if (lookup_take) begin
						rd_en <= 1'b1;
						rd_addr <= {pending_lookup.line, {WAY_BITS{1'b0}}};
						target_ip <= pending_lookup.ip;
						state <= LOOKUP_0;
					end else if (learn_take) begin
						rd_en <= 1'b1;
						rd_addr <= {pending_learn.line, {WAY_BITS{1'b0}}};
						target_ip <= pending_learn.ip;
						state <= LEARN_0;
					end
				end

				// Pipeline fill, nothing to look at yet
				LOOKUP_0, LOOKUP_1, LEARN_0, LEARN_1: begin
					rd_en <= 1'b1;
					rd_addr[WAY_BITS-1:0] <= next_way;
					case (state)
						LOOKUP_0: state <= LOOKUP_1;
						LOOKUP_1: state <= LOOKUP_2;
						LEARN_0: state <= LEARN_1;
						default: state <= LEARN_2;
					endcase
				end

				// Results arriving, keep issuing until the last way
				LOOKUP_2, LEARN_2: begin
					if (addr_at_end) begin
						state <= (state == LOOKUP_2) ? LOOKUP_3 : LEARN_3;
					end else begin
						rd_en <= 1'b1;
						rd_addr[WAY_BITS-1:0] <= next_way;
					end
				end

				// Draining the straggling reads
				LOOKUP_3: state <= LOOKUP_4;
				LEARN_3: state <= LEARN_4;

				// Last way checked and nothing found
				LOOKUP_4: begin
					lookup_done <= 1'b1;
					lookup_mac <= '1;
					state <= IDLE;
				end

				LEARN_4: state <= LEARN_5;

				// Not in the line, victim now covers every way
				LEARN_5: begin
					wr_en <= 1'b1;
					wr_addr <= victim_addr;
					wr_data <= '{ip: pending_learn.ip, mac: pending_learn.mac};
					state <= IDLE;
				end

				default: state <= IDLE;
			endcase

			// Early exit on a hit, overrides the case above
			if (match && in_lookup_scan) begin
				lookup_done <= 1'b1;
				lookup_hit <= 1'b1;
				lookup_mac <= match_mac;
				state <= IDLE;
			end

			// Refresh in place
			if (match && in_learn_scan) begin
				wr_en <= 1'b1;
				wr_addr <= match_addr;
				wr_data <= '{ip: pending_learn.ip, mac: pending_learn.mac};
				state <= IDLE;
			end
		end
	end

endmodule

// File: logic/arp_cache_pkg.sv
`include "arp_cache_cfg.svh"

package arp_cache_pkg;

	//////////////////////////////////////////////////////////////////////
	// Table row

	// One stored mapping, 80 bits
	// Valid flag is kept by the RAM next to the row
	typedef struct packed {
		logic [`ARP_IP_BITS-1:0] ip;
		logic [`ARP_MAC_BITS-1:0] mac;
	} arp_entry_t;

	//////////////////////////////////////////////////////////////////////
	// Pending requests

	// Learn waiting for the controller, hash already computed
	typedef struct packed {
		logic [`ARP_IP_BITS-1:0] ip;
		logic [`ARP_MAC_BITS-1:0] mac;
		logic [`ARP_LINE_BITS-1:0] line;
	} arp_learn_t;

	// Lookup waiting for the controller
	typedef struct packed {
		logic [`ARP_IP_BITS-1:0] ip;
		logic [`ARP_LINE_BITS-1:0] line;
	} arp_lookup_t;

	// Read data out of the table, tagged with its row
	typedef struct packed {
		logic valid;
		arp_entry_t entry;
		logic [`ARP_ADDR_BITS-1:0] addr;
	} arp_rd_result_t;

	// Controller states
	// Stages 0 and 1 only fill the read pipeline
	typedef enum logic [3:0] {
		IDLE = 4'h0,
		LOOKUP_0 = 4'h1,
		LOOKUP_1 = 4'h2,
		LOOKUP_2 = 4'h3,
		LOOKUP_3 = 4'h4,
		LOOKUP_4 = 4'h5,
		LEARN_0 = 4'h6,
		LEARN_1 = 4'h7,
		LEARN_2 = 4'h8,
		LEARN_3 = 4'h9,
		LEARN_4 = 4'ha,
		LEARN_5 = 4'hb
	} arp_state_t;

endpackage

// File: logic/arp_request_unit.sv
`timescale 1ns/1ps
`include "arp_cache_cfg.svh"

module arp_request_unit import arp_cache_pkg::*; (
	input logic clk,
	input logic reset,
	input logic lookup_en,
	input logic [`ARP_IP_BITS-1:0] lookup_ip,
	input logic learn_en,
	input logic [`ARP_IP_BITS-1:0] learn_ip,
	input logic [`ARP_MAC_BITS-1:0] learn_mac,
	input logic lookup_take,
	input logic learn_take,
	input logic learn_clear,
	output logic lookup_pending,
	output logic learn_pending,
	output arp_lookup_t pending_lookup,
	output arp_learn_t pending_learn
);

	localparam int LINE_BITS = `ARP_LINE_BITS;

	logic learn_held;
	logic learn_active;
	logic learn_accept;

	//////////////////////////////////////////////////////////////////////
	// Line hash

	// Byte sum xor low half, low bits pick the line
	function automatic logic [LINE_BITS-1:0] line_hash(input logic [`ARP_IP_BITS-1:0] ip);
		logic [15:0] byte_sum;
		byte_sum = 16'(ip[7:0]) + 16'(ip[15:8]) + 16'(ip[23:16]) + 16'(ip[31:24]);
		return LINE_BITS'(byte_sum ^ ip[15:0]);
	endfunction

	// A second learn while one is held is thrown away
	assign learn_accept = learn_en && !learn_held;

	// Held learn is hidden from the controller while it is being walked
	assign learn_pending = learn_held && !learn_active;

	always_ff @(posedge clk) begin
		if (reset) begin
			lookup_pending <= 1'b0;
			learn_held <= 1'b0;
			learn_active <= 1'b0;
		end else begin
			if (lookup_en) begin
				lookup_pending <= 1'b1;
			end else if (lookup_take) begin
				lookup_pending <= 1'b0;
			end

			if (learn_accept) begin
				learn_held <= 1'b1;
			end else if (learn_clear) begin
				learn_held <= 1'b0;
			end

			if (learn_take) begin
				learn_active <= 1'b1;
			end else if (learn_clear) begin
				learn_active <= 1'b0;
			end
		end
	end

	// Request payloads
	always_ff @(posedge clk) begin
		if (lookup_en) begin
			pending_lookup <= '{ip: lookup_ip, line: line_hash(lookup_ip)};
		end
		if (learn_accept) begin
			pending_learn <= '{ip: learn_ip, mac: learn_mac, line: line_hash(learn_ip)};
		end
	end

endmodule

// File: logic/arp_table_ram.sv
`timescale 1ns/1ps
`include "arp_cache_cfg.svh"

module arp_table_ram import arp_cache_pkg::*; #(
	parameter type ENTRY_T = arp_entry_t,
	parameter int ADDR_BITS = `ARP_ADDR_BITS
) (
	input logic clk,
	input logic reset,
	input logic rd_en,
	input logic [ADDR_BITS-1:0] rd_addr,
	input logic wr_en,
	input logic [ADDR_BITS-1:0] wr_addr,
	input ENTRY_T wr_data,
	output logic rd_valid,
	output ENTRY_T rd_data,
	output logic [ADDR_BITS-1:0] rd_data_addr
);

	localparam int DEPTH = 1 << ADDR_BITS;

	// Payload rows and their valid flags
	ENTRY_T mem [DEPTH];
	logic [DEPTH-1:0] valid_bits;

	// First read stage
	logic stage1_valid;
	ENTRY_T stage1_data;
	logic [ADDR_BITS-1:0] stage1_addr;

	//////////////////////////////////////////////////////////////////////
	// Valid flags

	// All rows empty out of reset, any write fills a row
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_bits <= '0;
			stage1_valid <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			if (wr_en) begin
				valid_bits[wr_addr] <= 1'b1;
			end
			if (rd_en) begin
				stage1_valid <= valid_bits[rd_addr];
			end
			rd_valid <= stage1_valid;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Payload storage and read pipe

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		// Address rides with the data so the scan knows the row
		if (rd_en) begin
			stage1_data <= mem[rd_addr];
			stage1_addr <= rd_addr;
		end
		rd_data <= stage1_data;
		rd_data_addr <= stage1_addr;
	end

endmodule

// File: logic/arp_way_scan.sv
`timescale 1ns/1ps
`include "arp_cache_cfg.svh"

module arp_way_scan import arp_cache_pkg::*; (
	input logic clk,
	input logic reset,
	input arp_rd_result_t rd_result,
	input logic scan_start,
	input logic scan_active,
	input logic [`ARP_IP_BITS-1:0] target_ip,
	output logic match,
	output logic [`ARP_ADDR_BITS-1:0] match_addr,
	output logic [`ARP_MAC_BITS-1:0] match_mac,
	output logic [`ARP_ADDR_BITS-1:0] victim_addr
);

	// Set once an empty way turns up in this walk
	logic empty_seen;

	//////////////////////////////////////////////////////////////////////
	// Hit detection

	assign match = scan_active && rd_result.valid && (rd_result.entry.ip == target_ip);
	assign match_addr = rd_result.addr;
	assign match_mac = rd_result.entry.mac;

	//////////////////////////////////////////////////////////////////////
	// Replacement choice

	always_ff @(posedge clk) begin
		if (reset) begin
			empty_seen <= 1'b0;
		end else if (scan_start) begin
			empty_seen <= 1'b0;
		end else if (scan_active && !match && !rd_result.valid) begin
			empty_seen <= 1'b1;
		end
	end

	// Latest empty way wins
	// full line falls back to whatever was scanned last
	always_ff @(posedge clk) begin
		if (scan_active && !match) begin
			if (!rd_result.valid || !empty_seen) begin
				victim_addr <= rd_result.addr;
			end
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the ARP cache testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
MDIR=obj_dir
EXE=arp_cache_sim

verilator --binary --timing --assert \
	--top-module arp_cache_tb \
	--Mdir "$MDIR" -o "$EXE" \
	-f arp_cache.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$MDIR/$EXE" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "test failed" "$LOG"; then
	echo "Simulation reported a failure, see $LOG"
	exit 1
fi

if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

exit 0

// File: verification/arp_cache_assert.sv
`timescale 1ns/1ps
`include "arp_cache_cfg.svh"

module arp_cache_assert (
	input logic clk,
	input logic reset,
	input logic lookup_take,
	input logic lookup_done,
	input logic lookup_hit
);

	localparam int MAX_WAIT = `ARP_NUM_WAYS + 4;

	// Lookup in flight and its age in cycles
	logic waiting;
	logic [7:0] wait_cycles;

	always_ff @(posedge clk) begin
		if (reset) begin
			waiting <= 1'b0;
			wait_cycles <= 8'd0;
		end else begin
			if (lookup_done) begin
				waiting <= 1'b0;
			end
			// Take can share a cycle with the previous done
			if (lookup_take) begin
				waiting <= 1'b1;
				wait_cycles <= 8'd0;
			end else if (waiting) begin
				wait_cycles <= wait_cycles + 8'd1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output pulse rules

	done_single: assert property (@(posedge clk) disable iff (reset)
		lookup_done |=> !lookup_done)
		else $error("lookup_done stayed high for two cycles");

	hit_with_done: assert property (@(posedge clk) disable iff (reset)
		lookup_hit |-> lookup_done)
		else $error("lookup_hit raised without lookup_done");

	// Full walk of the line plus pipeline fill
	// Take trails the accepted strobe by one cycle
	done_in_time: assert property (@(posedge clk) disable iff (reset)
		(waiting && !lookup_done) |-> (wait_cycles < 8'(MAX_WAIT - 1)))
		else $error("lookup_done late after accepted lookup");

	done_low_after_reset: assert property (@(posedge clk)
		$past(reset) |-> !lookup_done)
		else $error("lookup_done high right after reset");

endmodule

bind arp_cache arp_cache_assert cache_checker (
	.clk(clk),
	.reset(reset),
	.lookup_take(lookup_take),
	.lookup_done(lookup_done),
	.lookup_hit(lookup_hit)
);

// File: verification/arp_cache_tb.sv
`timescale 1ns/1ps
`include "arp_cache_cfg.svh"

module arp_cache_tb;

	localparam int NUM_WAYS = `ARP_NUM_WAYS;
	localparam int NUM_LINES = `ARP_LINES_PER_WAY;
	localparam int IP_BITS = `ARP_IP_BITS;
	localparam int MAC_BITS = `ARP_MAC_BITS;
	// Idle time after a learn, well above the write bound
	localparam int LEARN_GAP = 2 * (NUM_WAYS + 6);
	localparam int DONE_LIMIT = NUM_WAYS + 8;

	typedef enum logic {OP_LEARN, OP_LOOKUP} op_t;

	// One stimulus row
	// exp_hit only used by lookups
	typedef struct packed {
		op_t op;
		logic [IP_BITS-1:0] ip;
		logic [MAC_BITS-1:0] mac;
		logic back_to_back;
		logic exp_hit;
	} stim_row_t;

	logic clk;
	logic reset;
	logic lookup_en;
	logic [IP_BITS-1:0] lookup_ip;
	logic learn_en;
	logic [IP_BITS-1:0] learn_ip;
	logic [MAC_BITS-1:0] learn_mac;
	logic lookup_done;
	logic lookup_hit;
	logic [MAC_BITS-1:0] lookup_mac;

	stim_row_t stim_table [$];
	logic [IP_BITS-1:0] same_line [$];

	// Reference table, key is line * NUM_WAYS + way
	// a present key means a valid way
	logic [IP_BITS-1:0] model_ip [int];
	logic [MAC_BITS-1:0] model_mac [int];

	arp_cache DUT (
		.clk(clk),
		.reset(reset),
		.lookup_en(lookup_en),
		.lookup_ip(lookup_ip),
		.learn_en(learn_en),
		.learn_ip(learn_ip),
		.learn_mac(learn_mac),
		.lookup_done(lookup_done),
		.lookup_hit(lookup_hit),
		.lookup_mac(lookup_mac)
	);

	// 8 ns period
	always #4 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Reference model

	// Sum of the four bytes xor low 16 bits, low bits select the line
	function automatic int ip_line(input logic [IP_BITS-1:0] ip);
		int sum;
		sum = int'(ip[31:24]) + int'(ip[23:16]) + int'(ip[15:8]) + int'(ip[7:0]);
		return (sum ^ int'(ip[15:0])) % NUM_LINES;
	endfunction

	function automatic int model_key(input int line, input int way);
		return line * NUM_WAYS + way;
	endfunction

	// Refresh in place, else last empty way, else last way
	task automatic model_learn(input logic [IP_BITS-1:0] ip, input logic [MAC_BITS-1:0] mac);
		int line;
		int victim;
		bit found;
		line = ip_line(ip);
		victim = NUM_WAYS - 1;
		found = 1'b0;
		for (int way = 0; way < NUM_WAYS; way++) begin
			if (!model_ip.exists(model_key(line, way))) begin
				victim = way;
			end else if (model_ip[model_key(line, way)] == ip) begin
				model_mac[model_key(line, way)] = mac;
				found = 1'b1;
			end
		end
		if (!found) begin
			model_ip[model_key(line, victim)] = ip;
			model_mac[model_key(line, victim)] = mac;
		end
	endtask

	// Miss reads back as all ones
	task automatic model_lookup(input logic [IP_BITS-1:0] ip, output logic hit,
			output logic [MAC_BITS-1:0] mac);
		int line;
		line = ip_line(ip);
		hit = 1'b0;
		mac = '1;
		for (int way = 0; way < NUM_WAYS; way++) begin
			if (model_ip.exists(model_key(line, way)) && model_ip[model_key(line, way)] == ip) begin
				hit = 1'b1;
				mac = model_mac[model_key(line, way)];
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus table

	function automatic logic [MAC_BITS-1:0] random_mac();
		logic [63:0] bits;
		bits = {$urandom(), $urandom()};
		return bits[MAC_BITS-1:0];
	endfunction

	// IP of the learn that follows a back to back learn
	function automatic logic [IP_BITS-1:0] second_learn_ip(input logic [IP_BITS-1:0] ip);
		return ip + 32'h0000_0100;
	endfunction

	task automatic add_row(input op_t op, input logic [IP_BITS-1:0] ip,
			input logic [MAC_BITS-1:0] mac, input logic back_to_back, input logic exp_hit);
		stim_row_t row;
		row.op = op;
		row.ip = ip;
		row.mac = mac;
		row.back_to_back = back_to_back;
		row.exp_hit = exp_hit;
		stim_table.push_back(row);
	endtask

	// Collect count addresses from start upward that land on line
	task automatic find_colliding(input int line, input logic [IP_BITS-1:0] start, input int count);
		logic [IP_BITS-1:0] ip;
		same_line.delete();
		ip = start;
		while (same_line.size() < count) begin
			if (ip_line(ip) == line) begin
				same_line.push_back(ip);
			end
			ip = ip + 32'd1;
		end
	endtask

	task automatic build_table();
		logic [IP_BITS-1:0] ip_a;
		logic [IP_BITS-1:0] ip_b;
		logic [IP_BITS-1:0] ip_d;
		int line_a;
		int full_line;
		ip_a = 32'hc0a8_0001;
		ip_b = 32'hc0a8_0102;
		ip_d = 32'h0a01_0203;
		line_a = ip_line(ip_a);

		// Empty table misses everywhere
		add_row(OP_LOOKUP, ip_a, '0, 1'b0, 1'b0);
		add_row(OP_LOOKUP, 32'h0a00_0001, '0, 1'b0, 1'b0);

		// Learn then find
		add_row(OP_LEARN, ip_a, random_mac(), 1'b0, 1'b0);
		add_row(OP_LOOKUP, ip_a, '0, 1'b0, 1'b1);
		add_row(OP_LEARN, ip_b, random_mac(), 1'b0, 1'b0);
		add_row(OP_LOOKUP, ip_b, '0, 1'b0, 1'b1);

		// Neighbour in the same line, then a new MAC for A
		find_colliding(line_a, 32'h0a10_0000, 1);
		add_row(OP_LEARN, same_line[0], random_mac(), 1'b0, 1'b0);
		add_row(OP_LEARN, ip_a, random_mac(), 1'b0, 1'b0);
		add_row(OP_LOOKUP, ip_a, '0, 1'b0, 1'b1);
		add_row(OP_LOOKUP, same_line[0], '0, 1'b0, 1'b1);
		add_row(OP_LOOKUP, ip_b, '0, 1'b0, 1'b1);

		// Overfill an untouched line by one
		full_line = (line_a + 1) % NUM_LINES;
		while (full_line == line_a || full_line == ip_line(ip_b)) begin
			full_line = (full_line + 1) % NUM_LINES;
		end
		find_colliding(full_line, 32'h0a20_0000, NUM_WAYS + 1);
		foreach (same_line[i]) begin
			add_row(OP_LEARN, same_line[i], random_mac(), 1'b0, 1'b0);
		end
		// Oldest learn sat in the last way and was replaced
		foreach (same_line[i]) begin
			add_row(OP_LOOKUP, same_line[i], '0, 1'b0, (i != 0));
		end

		// Second learn right behind the first is lost
		add_row(OP_LEARN, ip_d, random_mac(), 1'b1, 1'b0);
		add_row(OP_LOOKUP, ip_d, '0, 1'b0, 1'b1);
		add_row(OP_LOOKUP, second_learn_ip(ip_d), '0, 1'b0, 1'b0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Driving and checking

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("[FAIL] t=%0t %s: got %0h, expected %0h", $time, what, actual, expected);
			$display("test failed");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	task automatic do_learn(input stim_row_t row);
		@(posedge clk);
		#1;
		learn_en = 1'b1;
		learn_ip = row.ip;
		learn_mac = row.mac;
		if (row.back_to_back) begin
			@(posedge clk);
			#1;
			// First learn still held here
			learn_ip = second_learn_ip(row.ip);
			learn_mac = random_mac();
		end
		@(posedge clk);
		#1;
		learn_en = 1'b0;
		repeat (LEARN_GAP) @(posedge clk);
	endtask

	task automatic do_lookup(input stim_row_t row);
		logic exp_hit;
		logic [MAC_BITS-1:0] exp_mac;
		int cycles;
		@(posedge clk);
		#1;
		lookup_en = 1'b1;
		lookup_ip = row.ip;
		@(posedge clk);
		#1;
		lookup_en = 1'b0;
		cycles = 1;
		// Outputs are sampled 1 ns after the edge that set them
		while (!lookup_done) begin
			if (cycles > DONE_LIMIT) begin
				$display("No lookup_done for IP %h within %0d cycles", row.ip, DONE_LIMIT);
				$display("test failed");
				$fatal(1, "lookup never completed");
			end
			@(posedge clk);
			#1;
			cycles++;
		end
		model_lookup(row.ip, exp_hit, exp_mac);
		check_value(64'(lookup_hit), 64'(row.exp_hit), "lookup_hit against table");
		check_value(64'(lookup_hit), 64'(exp_hit), "lookup_hit against model");
		check_value(64'(lookup_mac), 64'(exp_mac), "lookup_mac against model");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main flow and watchdog

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		lookup_en = 1'b0;
		lookup_ip = '0;
		learn_en = 1'b0;
		learn_ip = '0;
		learn_mac = '0;
		void'($urandom(32'h89a042fa));
		build_table();
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		foreach (stim_table[i]) begin
			if (stim_table[i].op == OP_LEARN) begin
				do_learn(stim_table[i]);
				// Dropped second learn never reaches the model
				model_learn(stim_table[i].ip, stim_table[i].mac);
			end else begin
				do_lookup(stim_table[i]);
			end
		end
		repeat (4) @(posedge clk);
		$display("test passed");
		$finish;
	end

	initial begin
		int limit;
		// Table is built at time zero
		#1;
		limit = stim_table.size() * 4 * (NUM_WAYS + 8) + 100;
		repeat (limit) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run did not finish", limit);
		$display("test failed");
		$fatal(1, "watchdog timeout");
	end

endmodule
